//--- source/sprite_pkg.sv
package sprite_pkg;

  localparam int INSTR_WIDTH = 36;
  localparam int WORD_WIDTH  = 32;
  localparam int NUM_REGS    = 32;
  localparam int NUM_SLOTS   = 64;
  localparam int NUM_FIELDS  = 8;
  localparam int FIELD_WIDTH = 16;

  typedef logic [INSTR_WIDTH-1:0]        instr_t;  // program word
  typedef logic [WORD_WIDTH-1:0]         word_t;   // register value
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
  typedef logic [$clog2(NUM_SLOTS)-1:0]  slot_idx_t;
  typedef logic [$clog2(NUM_FIELDS)-1:0] field_idx_t;
  typedef logic [FIELD_WIDTH-1:0]        field_t;

  // opcode = {bit 32, bits 6:0}
  localparam logic [7:0] OP_LI     = 8'h37;
  localparam logic [7:0] OP_REG    = 8'h33;
  localparam logic [7:0] OP_IMM    = 8'h13;
  localparam logic [7:0] OP_BRANCH = 8'h63;
  localparam logic [7:0] OP_JMP    = 8'h61;
  localparam logic [7:0] OP_SPLI   = 8'hB7;
  localparam logic [7:0] OP_SPLREG = 8'h81;
  localparam logic [7:0] OP_LISP   = 8'hBF;
  localparam logic [7:0] OP_DIST   = 8'hFF;

  // variant selects
  localparam logic [6:0] F7_ADD  = 7'd0;
  localparam logic [6:0] F7_SUB  = 7'd1;
  localparam logic [6:0] F7_ABS  = 7'd5;
  localparam logic [2:0] F3_ADDI = 3'd0;
  localparam logic [2:0] F3_SUBI = 3'd1;
  localparam logic [2:0] F3_BEQ  = 3'd0;
  localparam logic [2:0] F3_BNE  = 3'd1;
  localparam logic [2:0] F3_BLT  = 3'd4;
  localparam logic [2:0] F3_BGE  = 3'd5;

  typedef enum logic [3:0] {
    ALU_PASS, ALU_ADD, ALU_SUB, ALU_ABS, ALU_DIST,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE
  } alu_op_t;

  // sprite fields, kind 0 marks an empty slot
  localparam field_idx_t FIELD_KIND  = 3'd0;
  localparam field_idx_t FIELD_X     = 3'd1;
  localparam field_idx_t FIELD_Y     = 3'd2;
  localparam field_idx_t FIELD_FRAME = 3'd3;

  function automatic logic [7:0] op_of(instr_t i);
    return {i[32], i[6:0]};
  endfunction
  function automatic reg_idx_t rd_of(instr_t i);
    return i[11:7];
  endfunction
  function automatic logic [2:0] funct3_of(instr_t i);
    return i[14:12];
  endfunction
  function automatic reg_idx_t rs_b_of(instr_t i);
    return i[19:15];
  endfunction
  function automatic reg_idx_t rs_a_of(instr_t i);
    return i[24:20];
  endfunction
  function automatic logic [6:0] funct7_of(instr_t i);
    return i[31:25];
  endfunction
  function automatic logic [19:0] uimm_of(instr_t i);
    return i[31:12];
  endfunction
  function automatic logic [11:0] simm_of(instr_t i);
    return i[31:20];
  endfunction
  function automatic reg_idx_t sreg_of(instr_t i);
    return i[16:12];  // SPLREG slot register
  endfunction
  function automatic field_idx_t fsel_of(instr_t i);
    return i[35:33];
  endfunction
  function automatic logic [11:0] btarget_of(instr_t i);
    return {i[31:25], i[11:7]};
  endfunction
  function automatic logic [24:0] jtarget_of(instr_t i);
    return i[31:7];
  endfunction

endpackage

//--- source/sprite_port_if.sv
`timescale 1ns/1ns
interface sprite_port_if;
  import sprite_pkg::*;

  // single write port, core side
  logic       wr_en;
  slot_idx_t  wr_slot;
  field_idx_t wr_field;
  field_t     wr_data;

  // four combinational reads
  slot_idx_t  rd_slot  [4];
  field_idx_t rd_field [4];
  field_t     rd_data  [4];

  modport core (
    output wr_en, wr_slot, wr_field, wr_data, rd_slot, rd_field,
    input  rd_data
  );
  modport tbl (
    input  wr_en, wr_slot, wr_field, wr_data, rd_slot, rd_field,
    output rd_data
  );
endinterface

//--- source/program_rom.sv
`timescale 1ns/1ns
module program_rom #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                          pixel_clk_in,
  input  logic                          prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
  input  sprite_pkg::instr_t            prog_data,
  input  logic [$clog2(PROG_DEPTH)-1:0] fetch_addr,
  output sprite_pkg::instr_t            fetch_word
);
  import sprite_pkg::*;

  instr_t mem [PROG_DEPTH];  // survives reset, host reloads it

  always_ff @(posedge pixel_clk_in) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;  // host side, no flow control
    end
    fetch_word <= mem[fetch_addr];  // read first, 1 cycle latency
  end

endmodule

//--- source/core_control.sv
`timescale 1ns/1ns
module core_control #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                          pixel_clk_in,
  input  logic                          rst_in,
  input  logic                          restart,
  input  sprite_pkg::instr_t            fetch_word,
  input  sprite_pkg::word_t             rdata0,
  input  sprite_pkg::word_t             rdata1,
  input  sprite_pkg::word_t             rdata2,
  input  sprite_pkg::word_t             rdata3,
  input  sprite_pkg::word_t             result,
  output logic [$clog2(PROG_DEPTH)-1:0] fetch_addr,
  output sprite_pkg::reg_idx_t          ra0,
  output sprite_pkg::reg_idx_t          ra1,
  output sprite_pkg::reg_idx_t          ra2,
  output sprite_pkg::reg_idx_t          ra3,
  output logic                          reg_we,
  output sprite_pkg::reg_idx_t          reg_wr_idx,
  output sprite_pkg::word_t             reg_wr_data,
  output sprite_pkg::alu_op_t           alu_op,
  output sprite_pkg::word_t             operand_a,
  output sprite_pkg::word_t             operand_b,
  output sprite_pkg::word_t             operand_c,
  output sprite_pkg::word_t             operand_d,
  sprite_port_if.core                   sp
);
  import sprite_pkg::*;

  localparam int PC_W = $clog2(PROG_DEPTH) + 1;  // top bit catches running off the end

  typedef enum logic [1:0] {FETCH, DECODE, EXECUTE, WRITEBACK} stage_t;
  typedef enum logic [1:0] {DST_REG, DST_SPRITE, DST_BRANCH, DST_JUMP} dest_t;

  stage_t          stage;
  logic [PC_W-1:0] pc;
  logic [PC_W-1:0] pc_next;
  logic            halted;
  instr_t          instr_q;  // word in flight
  dest_t           dest_q;
  slot_idx_t       slot_q;   // target slot of SPLI / SPLREG
  logic [7:0]      opcode;
  alu_op_t         op_d;
  word_t           a_d, b_d, c_d, d_d;
  dest_t           dest_d;
  logic            known_d;

  assign opcode     = op_of(fetch_word);  // rom word is valid in DECODE
  assign fetch_addr = pc[PC_W-2:0];

  // register read ports, fixed roles
  assign ra0 = rs_b_of(fetch_word);
  assign ra1 = rs_a_of(fetch_word);
  assign ra2 = rd_of(fetch_word);   // SPLI slot, SPLREG value
  assign ra3 = sreg_of(fetch_word); // SPLREG slot

  // port 0 doubles as the LISP read
  assign sp.rd_slot[0]  = slot_idx_t'(rdata0);
  assign sp.rd_field[0] = (opcode == OP_DIST) ? FIELD_X : fsel_of(fetch_word);
  assign sp.rd_slot[1]  = slot_idx_t'(rdata1);
  assign sp.rd_field[1] = FIELD_X;
  assign sp.rd_slot[2]  = slot_idx_t'(rdata0);
  assign sp.rd_field[2] = FIELD_Y;
  assign sp.rd_slot[3]  = slot_idx_t'(rdata1);
  assign sp.rd_field[3] = FIELD_Y;

  // decode
  always_comb begin
    op_d    = ALU_PASS;
    a_d     = '0;
    b_d     = '0;
    c_d     = '0;
    d_d     = '0;
    dest_d  = DST_REG;
    known_d = 1'b1;
    case (opcode)
      OP_LI:   a_d = word_t'(uimm_of(fetch_word));
      OP_SPLI: begin
        a_d    = word_t'(uimm_of(fetch_word));
        dest_d = DST_SPRITE;
      end
      OP_SPLREG: begin
        a_d    = rdata2;
        dest_d = DST_SPRITE;
      end
      OP_REG: begin
        a_d = rdata0;  // rd = rs_b op rs_a
        b_d = rdata1;
        case (funct7_of(fetch_word))
          F7_ADD:  op_d = ALU_ADD;
          F7_SUB:  op_d = ALU_SUB;
          F7_ABS:  op_d = ALU_ABS;
          default: known_d = 1'b0;
        endcase
      end
      OP_IMM: begin
        a_d = rdata0;
        b_d = word_t'(simm_of(fetch_word));  // zero extended
        case (funct3_of(fetch_word))
          F3_ADDI: op_d = ALU_ADD;
          F3_SUBI: op_d = ALU_SUB;
          default: known_d = 1'b0;
        endcase
      end
      OP_BRANCH: begin
        a_d    = rdata1;  // rs_a against rs_b, unsigned
        b_d    = rdata0;
        dest_d = DST_BRANCH;
        case (funct3_of(fetch_word))
          F3_BEQ:  op_d = ALU_EQ;
          F3_BNE:  op_d = ALU_NE;
          F3_BLT:  op_d = ALU_LT;
          F3_BGE:  op_d = ALU_GE;
          default: known_d = 1'b0;
        endcase
      end
      OP_JMP:  dest_d = DST_JUMP;
      OP_LISP: a_d = word_t'(sp.rd_data[0]);
      OP_DIST: begin
        op_d = ALU_DIST;
        a_d  = word_t'(sp.rd_data[0]);  // x pair
        b_d  = word_t'(sp.rd_data[1]);
        c_d  = word_t'(sp.rd_data[2]);  // y pair
        d_d  = word_t'(sp.rd_data[3]);
      end
      default: known_d = 1'b0;  // includes the zero terminator
    endcase
  end

  // latched at the end of DECODE
  always_ff @(posedge pixel_clk_in) begin
    if (stage == DECODE) begin
      instr_q   <= fetch_word;
      dest_q    <= dest_d;
      slot_q    <= slot_idx_t'((opcode == OP_SPLREG) ? rdata3 : rdata2);
      alu_op    <= op_d;
      operand_a <= a_d;
      operand_b <= b_d;
      operand_c <= c_d;
      operand_d <= d_d;
    end
  end

  always_comb begin
    case (dest_q)
      DST_BRANCH: pc_next = result[0] ? PC_W'(btarget_of(instr_q)) : pc + 1'b1;
      DST_JUMP:   pc_next = PC_W'(jtarget_of(instr_q));
      default:    pc_next = pc + 1'b1;
    endcase
  end

  // stage sequencer
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in || restart) begin
      pc     <= '0;
      stage  <= FETCH;
      halted <= 1'b0;
    end else begin
      case (stage)
        FETCH: begin
          if (pc >= PC_W'(PROG_DEPTH)) begin
            halted <= 1'b1;  // ran past the end
          end else if (!halted) begin
            stage <= DECODE;
          end
        end
        DECODE: begin
          stage  <= known_d ? EXECUTE : FETCH;
          halted <= !known_d;
        end
        EXECUTE:   stage <= WRITEBACK;
        WRITEBACK: begin
          pc    <= pc_next;
          stage <= FETCH;
        end
      endcase
    end
  end

  // writeback, a restart in the same cycle wins
  assign reg_we      = (stage == WRITEBACK) && (dest_q == DST_REG) && !restart;
  assign reg_wr_idx  = rd_of(instr_q);
  assign reg_wr_data = result;
  assign sp.wr_en    = (stage == WRITEBACK) && (dest_q == DST_SPRITE) && !restart;
  assign sp.wr_slot  = slot_q;
  assign sp.wr_field = fsel_of(instr_q);
  assign sp.wr_data  = field_t'(result);  // low 16 bits

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns
module reg_file (
  input  logic                 pixel_clk_in,
  input  sprite_pkg::reg_idx_t ra0,
  input  sprite_pkg::reg_idx_t ra1,
  input  sprite_pkg::reg_idx_t ra2,
  input  sprite_pkg::reg_idx_t ra3,
  input  logic                 we,
  input  sprite_pkg::reg_idx_t wr_idx,
  input  sprite_pkg::word_t    wr_data,
  output sprite_pkg::word_t    rdata0,
  output sprite_pkg::word_t    rdata1,
  output sprite_pkg::word_t    rdata2,
  output sprite_pkg::word_t    rdata3
);
  import sprite_pkg::*;

  word_t regs [NUM_REGS];  // x0 is an ordinary register here

  assign rdata0 = regs[ra0];
  assign rdata1 = regs[ra1];
  assign rdata2 = regs[ra2];
  assign rdata3 = regs[ra3];

  always_ff @(posedge pixel_clk_in) begin
    if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

//--- source/exec_unit.sv
`timescale 1ns/1ns
module exec_unit (
  input  logic                pixel_clk_in,
  input  sprite_pkg::alu_op_t alu_op,
  input  sprite_pkg::word_t   operand_a,
  input  sprite_pkg::word_t   operand_b,
  input  sprite_pkg::word_t   operand_c,
  input  sprite_pkg::word_t   operand_d,
  output sprite_pkg::word_t   result
);
  import sprite_pkg::*;

  word_t diff_ab;
  word_t diff_cd;

  function automatic word_t abs_diff(word_t p, word_t q);
    return (p >= q) ? p - q : q - p;
  endfunction

  assign diff_ab = abs_diff(operand_a, operand_b);
  assign diff_cd = abs_diff(operand_c, operand_d);  // y part of DIST

  // operands are held from DECODE on, so result settles at the end of EXECUTE
  always_ff @(posedge pixel_clk_in) begin
    case (alu_op)
      ALU_ADD:  result <= operand_a + operand_b;
      ALU_SUB:  result <= (operand_a >= operand_b) ? operand_a - operand_b : '0;  // floor 0
      ALU_ABS:  result <= diff_ab;
      ALU_DIST: result <= diff_ab + diff_cd;  // manhattan
      ALU_EQ:   result <= word_t'(operand_a == operand_b);
      ALU_NE:   result <= word_t'(operand_a != operand_b);
      ALU_LT:   result <= word_t'(operand_a < operand_b);
      ALU_GE:   result <= word_t'(operand_a >= operand_b);
      default:  result <= operand_a;  // pass, LI / SP* / LISP
    endcase
  end

endmodule

//--- source/sprite_table.sv
`timescale 1ns/1ns
module sprite_table (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  sprite_pkg::slot_idx_t scan_slot,
  output sprite_pkg::field_t    scan_kind,
  output sprite_pkg::field_t    scan_x,
  output sprite_pkg::field_t    scan_y,
  output sprite_pkg::field_t    scan_frame,
  sprite_port_if.tbl            sp
);
  import sprite_pkg::*;

  field_t fields [NUM_SLOTS][NUM_FIELDS];

  // only kinds are cleared, other fields keep garbage until written
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        fields[s][FIELD_KIND] <= '0;
      end
    end else if (sp.wr_en) begin
      fields[sp.wr_slot][sp.wr_field] <= sp.wr_data;
    end
  end

  // core reads
  always_comb begin
    for (int p = 0; p < 4; p++) begin
      sp.rd_data[p] = fields[sp.rd_slot[p]][sp.rd_field[p]];
    end
  end

  // scanout sees the whole slot at once
  assign scan_kind  = fields[scan_slot][FIELD_KIND];
  assign scan_x     = fields[scan_slot][FIELD_X];
  assign scan_y     = fields[scan_slot][FIELD_Y];
  assign scan_frame = fields[scan_slot][FIELD_FRAME];

endmodule

//--- source/sprite_scanout.sv
`timescale 1ns/1ns
module sprite_scanout #(
  parameter int DWELL_CYCLES  = 25000,
  parameter int CANVAS_WIDTH  = 1024,
  parameter int CANVAS_HEIGHT = 768,
  parameter int NUM_FRAMES    = 16
) (
  input  logic                             pixel_clk_in,
  input  logic                             rst_in,
  input  logic                             new_frame,
  input  sprite_pkg::field_t               scan_kind,
  input  sprite_pkg::field_t               scan_x,
  input  sprite_pkg::field_t               scan_y,
  input  sprite_pkg::field_t               scan_frame,
  output sprite_pkg::slot_idx_t            scan_slot,
  output logic [$clog2(CANVAS_WIDTH)-1:0]  x,
  output logic [$clog2(CANVAS_HEIGHT)-1:0] y,
  output logic [$clog2(NUM_FRAMES)-1:0]    frame,
  output logic                             sprite_valid
);
  import sprite_pkg::*;

  localparam int SLOT_W  = $clog2(NUM_SLOTS) + 1;  // one past the last slot = done
  localparam int DWELL_W = $clog2(DWELL_CYCLES + 1);

  logic [SLOT_W-1:0]  slot;
  logic [DWELL_W-1:0] dwell;
  logic               scanning;

  assign scanning  = slot < SLOT_W'(NUM_SLOTS);
  assign scan_slot = slot_idx_t'(slot);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      slot  <= SLOT_W'(NUM_SLOTS);  // idle until the first frame
      dwell <= '0;
    end else if (new_frame) begin
      slot  <= '0;  // restart even mid scan
      dwell <= '0;
    end else if (scanning) begin
      if (dwell == DWELL_W'(DWELL_CYCLES - 1)) begin
        dwell <= '0;
        slot  <= slot + 1'b1;
      end else begin
        dwell <= dwell + 1'b1;
      end
    end
  end

  // one cycle behind the table read
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      sprite_valid <= 1'b0;
    end else begin
      sprite_valid <= scanning && (scan_kind != '0);  // kind 0 = empty slot
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    x     <= scan_x[$clog2(CANVAS_WIDTH)-1:0];
    y     <= scan_y[$clog2(CANVAS_HEIGHT)-1:0];
    frame <= scan_frame[$clog2(NUM_FRAMES)-1:0];
  end

endmodule

//--- source/sprite_core_top.sv
`timescale 1ns/1ns
module sprite_core_top #(
  parameter int PROG_DEPTH    = 256,
  parameter int DWELL_CYCLES  = 25000,
  parameter int CANVAS_WIDTH  = 1024,
  parameter int CANVAS_HEIGHT = 768,
  parameter int NUM_FRAMES    = 16
) (
  input  logic                             pixel_clk_in,
  input  logic                             rst_in,
  input  logic                             new_frame,
  input  logic                             prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0]    prog_addr,
  input  sprite_pkg::instr_t               prog_data,
  output logic [$clog2(CANVAS_WIDTH)-1:0]  x,
  output logic [$clog2(CANVAS_HEIGHT)-1:0] y,
  output logic [$clog2(NUM_FRAMES)-1:0]    frame,
  output logic                             sprite_valid
);
  import sprite_pkg::*;

  logic [$clog2(PROG_DEPTH)-1:0] fetch_addr;
  instr_t    fetch_word;
  logic      restart;
  reg_idx_t  ra0, ra1, ra2, ra3;
  word_t     rdata0, rdata1, rdata2, rdata3;
  logic      reg_we;
  reg_idx_t  reg_wr_idx;
  word_t     reg_wr_data;
  alu_op_t   alu_op;
  word_t     operand_a, operand_b, operand_c, operand_d;
  word_t     result;
  slot_idx_t scan_slot;
  field_t    scan_kind, scan_x, scan_y, scan_frame;

  sprite_port_if sprite_port ();

  assign restart = prog_we && (prog_addr == '0);  // writing word 0 reboots the core

  program_rom #(.PROG_DEPTH(PROG_DEPTH)) program_rom_inst (
    .pixel_clk_in, .prog_we, .prog_addr, .prog_data, .fetch_addr, .fetch_word
  );

  core_control #(.PROG_DEPTH(PROG_DEPTH)) core_control_inst (
    .pixel_clk_in, .rst_in, .restart, .fetch_word,
    .rdata0, .rdata1, .rdata2, .rdata3, .result, .fetch_addr,
    .ra0, .ra1, .ra2, .ra3, .reg_we, .reg_wr_idx, .reg_wr_data,
    .alu_op, .operand_a, .operand_b, .operand_c, .operand_d,
    .sp(sprite_port.core)
  );

  reg_file reg_file_inst (
    .pixel_clk_in, .ra0, .ra1, .ra2, .ra3,
    .we(reg_we), .wr_idx(reg_wr_idx), .wr_data(reg_wr_data),
    .rdata0, .rdata1, .rdata2, .rdata3
  );

  exec_unit exec_unit_inst (
    .pixel_clk_in, .alu_op, .operand_a, .operand_b, .operand_c, .operand_d, .result
  );

  sprite_table sprite_table_inst (
    .pixel_clk_in, .rst_in, .scan_slot, .scan_kind, .scan_x, .scan_y, .scan_frame,
    .sp(sprite_port.tbl)
  );

  sprite_scanout #(
    .DWELL_CYCLES(DWELL_CYCLES), .CANVAS_WIDTH(CANVAS_WIDTH),
    .CANVAS_HEIGHT(CANVAS_HEIGHT), .NUM_FRAMES(NUM_FRAMES)
  ) sprite_scanout_inst (
    .pixel_clk_in, .rst_in, .new_frame, .scan_kind, .scan_x, .scan_y, .scan_frame,
    .scan_slot, .x, .y, .frame, .sprite_valid
  );

endmodule

//--- include/program_asm.svh
`ifndef PROGRAM_ASM_SVH
`define PROGRAM_ASM_SVH

// register layout, opcode bit 7 goes to word bit 32
function automatic sprite_pkg::instr_t enc_r(logic [7:0] op, logic [6:0] f7, logic [4:0] rs_a,
    logic [4:0] rs_b, logic [2:0] f3, logic [4:0] rd, logic [2:0] fsel);
  return {fsel, op[7], f7, rs_a, rs_b, f3, rd, op[6:0]};
endfunction

// 20 bit immediate in bits 31:12
function automatic sprite_pkg::instr_t enc_u(logic [7:0] op, logic [2:0] fsel,
    logic [19:0] imm, logic [4:0] rd);
  return {fsel, op[7], imm, rd, op[6:0]};
endfunction

function automatic sprite_pkg::instr_t asm_li(logic [4:0] rd, logic [19:0] imm);
  return enc_u(sprite_pkg::OP_LI, 3'd0, imm, rd);
endfunction

// rd = rs1 op rs2; rs1 sits in the rs_b field
function automatic sprite_pkg::instr_t asm_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
  return enc_r(sprite_pkg::OP_REG, sprite_pkg::F7_ADD, rs2, rs1, 3'd0, rd, 3'd0);
endfunction
function automatic sprite_pkg::instr_t asm_sub(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
  return enc_r(sprite_pkg::OP_REG, sprite_pkg::F7_SUB, rs2, rs1, 3'd0, rd, 3'd0);
endfunction
function automatic sprite_pkg::instr_t asm_abs(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
  return enc_r(sprite_pkg::OP_REG, sprite_pkg::F7_ABS, rs2, rs1, 3'd0, rd, 3'd0);
endfunction

function automatic sprite_pkg::instr_t asm_addi(logic [4:0] rd, logic [4:0] rs, logic [11:0] imm);
  return enc_r(sprite_pkg::OP_IMM, imm[11:5], imm[4:0], rs, sprite_pkg::F3_ADDI, rd, 3'd0);
endfunction
function automatic sprite_pkg::instr_t asm_subi(logic [4:0] rd, logic [4:0] rs, logic [11:0] imm);
  return enc_r(sprite_pkg::OP_IMM, imm[11:5], imm[4:0], rs, sprite_pkg::F3_SUBI, rd, 3'd0);
endfunction

// f3 picks BEQ / BNE / BLT / BGE, taken when rs_a cmp rs_b holds
function automatic sprite_pkg::instr_t asm_branch(logic [2:0] f3, logic [4:0] rs_a,
    logic [4:0] rs_b, logic [11:0] target);
  return enc_r(sprite_pkg::OP_BRANCH, target[11:5], rs_a, rs_b, f3, target[4:0], 3'd0);
endfunction

function automatic sprite_pkg::instr_t asm_jmp(logic [24:0] target);
  return enc_u(sprite_pkg::OP_JMP, 3'd0, target[24:5], target[4:0]);
endfunction

// slot comes from register slot_reg
function automatic sprite_pkg::instr_t asm_spli(logic [4:0] slot_reg, logic [2:0] field,
    logic [19:0] imm);
  return enc_u(sprite_pkg::OP_SPLI, field, imm, slot_reg);
endfunction
function automatic sprite_pkg::instr_t asm_splreg(logic [4:0] slot_reg, logic [2:0] field,
    logic [4:0] val_reg);
  return enc_u(sprite_pkg::OP_SPLREG, field, {15'd0, slot_reg}, val_reg);
endfunction

function automatic sprite_pkg::instr_t asm_lisp(logic [4:0] rd, logic [4:0] slot_reg,
    logic [2:0] field);
  return enc_r(sprite_pkg::OP_LISP, 7'd0, 5'd0, slot_reg, 3'd0, rd, field);
endfunction
function automatic sprite_pkg::instr_t asm_dist(logic [4:0] rd, logic [4:0] slot_a,
    logic [4:0] slot_b);
  return enc_r(sprite_pkg::OP_DIST, 7'd0, slot_a, slot_b, 3'd0, rd, 3'd0);
endfunction

`endif

//--- tests/sprite_core_tb.sv
`timescale 1ns/1ns
module sprite_core_tb;
  import sprite_pkg::*;
  `include "program_asm.svh"

  localparam int DWELL      = 4;
  localparam int SCAN_LEN   = NUM_SLOTS * DWELL;  // cycles of one scan
  localparam int NUM_FRAMES = 5;                  // tests 2 to 6 scan once each
  localparam int MAX_WORDS  = 400;  // bound on words written plus instructions run
  // 8 cycles per word covers the write and 4 cycles of execution
  localparam int WATCHDOG   = 16 + 8 * MAX_WORDS + NUM_FRAMES * (SCAN_LEN + 16) + 1000;

  logic       pixel_clk_in = 1'b0;
  logic       rst_in;
  logic       new_frame;
  logic       prog_we;
  logic [7:0] prog_addr;
  instr_t     prog_data;
  logic [9:0] x;
  logic [9:0] y;
  logic [3:0] frame;
  logic       sprite_valid;

  // reference copy of the sprite table
  field_t m_kind [NUM_SLOTS];
  field_t m_x    [NUM_SLOTS];
  field_t m_y    [NUM_SLOTS];
  field_t m_fr   [NUM_SLOTS];

  instr_t    prog [$];       // program under construction
  int        exec_count = 0; // instructions it will run
  int        err_count  = 0;
  int        err_mark   = 0;
  int        pass_tests = 0;
  int        fail_tests = 0;
  int        scan_pos;       // cycles since new_frame was taken
  logic      shown;
  slot_idx_t cur_slot;
  logic      exp_valid;
  logic [9:0] exp_x, exp_y;
  logic [3:0] exp_frame;

  always #50 pixel_clk_in = ~pixel_clk_in;

  sprite_core_top #(.DWELL_CYCLES(DWELL)) sprite_core_top_inst (
    .pixel_clk_in, .rst_in, .new_frame, .prog_we, .prog_addr, .prog_data,
    .x, .y, .frame, .sprite_valid
  );

  // slot k reaches the outputs at scan_pos 4k+1 .. 4k+4
  always @(posedge pixel_clk_in) begin
    if (rst_in) begin
      scan_pos <= SCAN_LEN + 1;  // idle
    end else if (new_frame) begin
      scan_pos <= 0;
    end else if (scan_pos <= SCAN_LEN) begin
      scan_pos <= scan_pos + 1;
    end
  end

  assign shown     = (scan_pos >= 1) && (scan_pos <= SCAN_LEN);
  assign cur_slot  = shown ? slot_idx_t'((scan_pos - 1) / DWELL) : '0;
  assign exp_valid = shown && (m_kind[cur_slot] != '0);  // empty slots stay dark
  assign exp_x     = m_x[cur_slot][9:0];
  assign exp_y     = m_y[cur_slot][9:0];
  assign exp_frame = m_fr[cur_slot][3:0];

  valid_chk: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      sprite_valid == exp_valid)
    else begin
      $display("** Error: sprite_valid expected %h got %h (slot %0d)",
               exp_valid, sprite_valid, cur_slot);
      err_count++;
    end
  x_chk: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      sprite_valid |-> x == exp_x)
    else begin
      $display("** Error: x expected %h got %h (slot %0d)", exp_x, x, cur_slot);
      err_count++;
    end
  y_chk: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      sprite_valid |-> y == exp_y)
    else begin
      $display("** Error: y expected %h got %h (slot %0d)", exp_y, y, cur_slot);
      err_count++;
    end
  frame_chk: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
      sprite_valid |-> frame == exp_frame)
    else begin
      $display("** Error: frame expected %h got %h (slot %0d)", exp_frame, frame, cur_slot);
      err_count++;
    end

  function automatic field_t nonzero_field();
    return field_t'($urandom_range(1, 65535));
  endfunction

  function automatic field_t any_field();
    return field_t'($urandom);
  endfunction

  function automatic slot_idx_t pick_free();
    slot_idx_t s;
    do begin
      s = slot_idx_t'($urandom);
    end while (m_kind[s] != '0);
    return s;
  endfunction

  task automatic emit(instr_t w);
    prog.push_back(w);
    exec_count++;
  endtask

  // slot number goes through r1, which stays set for a later SPLREG
  task automatic place(slot_idx_t s, field_t kind, field_t px, field_t py, field_t pf);
    emit(asm_li(5'd1, 20'(s)));
    emit(asm_spli(5'd1, FIELD_KIND, 20'(kind)));
    emit(asm_spli(5'd1, FIELD_X, 20'(px)));
    emit(asm_spli(5'd1, FIELD_Y, 20'(py)));
    emit(asm_spli(5'd1, FIELD_FRAME, 20'(pf)));
    m_kind[s] = kind;
    m_x[s]    = px;
    m_y[s]    = py;
    m_fr[s]   = pf;
  endtask

  // one ALU op into the x field of a fresh slot
  task automatic alu_case(instr_t op, reg_idx_t rd, word_t expected);
    slot_idx_t s;
    s = pick_free();
    place(s, nonzero_field(), any_field(), any_field(), any_field());
    emit(op);
    emit(asm_splreg(5'd1, FIELD_X, rd));
    m_x[s] = field_t'(expected);  // field keeps the low 16 bits
  endtask

  task automatic write_word(logic [7:0] addr, instr_t w);
    @(posedge pixel_clk_in);
    prog_we   <= 1'b1;
    prog_addr <= addr;
    prog_data <= w;
  endtask

  // word 0 goes last so the restart sees a complete program
  task automatic load_program();
    prog.push_back('0);  // terminator
    for (int i = 1; i < prog.size(); i++) begin
      write_word(8'(i), prog[i]);
    end
    write_word(8'd0, prog[0]);
    @(posedge pixel_clk_in);
    prog_we <= 1'b0;
    repeat (4 * exec_count + 16) @(posedge pixel_clk_in);  // 4 cycles per instruction
    prog.delete();
    exec_count = 0;
  endtask

  task automatic run_frame();
    int vcount;
    int busy;
    vcount = 0;
    busy   = 0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (m_kind[s] != '0) busy++;
    end
    @(posedge pixel_clk_in);
    new_frame <= 1'b1;
    @(posedge pixel_clk_in);
    new_frame <= 1'b0;
    repeat (SCAN_LEN + 8) begin
      @(posedge pixel_clk_in);
      if (sprite_valid) vcount++;
    end
    count_chk: assert (vcount == DWELL * busy)
      else begin
        $display("** Error: sprite_valid cycles expected %h got %h", DWELL * busy, vcount);
        err_count++;
      end
  endtask

  task automatic finish_test(int num, string name);
    if (err_count == err_mark) begin
      pass_tests++;
      $display("test %0d %s: passed", num, name);
    end else begin
      fail_tests++;
      $display("test %0d %s: failed, %0d errors", num, name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  initial begin
    slot_idx_t   s0, s1, ls, poison, dst, d0, d1, dd, so;
    word_t       a, b;
    logic [11:0] imm;
    int          n, loop_top, br, dx, dy;
    void'($urandom(32890));
    rst_in    = 1'b1;
    new_frame = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      m_kind[s] = '0;
      m_x[s]    = '0;
      m_y[s]    = '0;
      m_fr[s]   = '0;
    end
    repeat (16) @(posedge pixel_clk_in);
    rst_in <= 1'b0;

    repeat (3 * SCAN_LEN / 8) @(posedge pixel_clk_in);  // no frame yet, must stay dark
    finish_test(1, "idle after reset");

    s0 = pick_free();
    place(s0, nonzero_field(), any_field(), any_field(), any_field());
    s1 = pick_free();
    place(s1, nonzero_field(), any_field(), any_field(), any_field());
    load_program();
    run_frame();
    finish_test(2, "LI and SPLI");

    a   = word_t'($urandom_range(1000, 1000000));  // a > b, a > imm
    b   = word_t'($urandom_range(1, 999));
    imm = 12'($urandom_range(1, 999));
    emit(asm_li(5'd3, 20'(a)));
    emit(asm_li(5'd4, 20'(b)));
    alu_case(asm_add(5'd5, 5'd3, 5'd4), 5'd5, a + b);
    alu_case(asm_addi(5'd6, 5'd3, imm), 5'd6, a + word_t'(imm));
    alu_case(asm_sub(5'd7, 5'd3, 5'd4), 5'd7, a - b);
    alu_case(asm_sub(5'd8, 5'd4, 5'd3), 5'd8, '0);  // b - a floors at 0
    alu_case(asm_subi(5'd9, 5'd3, imm), 5'd9, a - word_t'(imm));
    alu_case(asm_abs(5'd10, 5'd4, 5'd3), 5'd10, a - b);
    load_program();
    run_frame();
    finish_test(3, "arithmetic");

    n  = $urandom_range(3, 9);
    ls = pick_free();
    place(ls, nonzero_field(), '0, any_field(), any_field());
    emit(asm_li(5'd11, 20'd0));
    emit(asm_li(5'd12, 20'(n)));
    loop_top = prog.size();
    emit(asm_addi(5'd11, 5'd11, 12'd1));
    emit(asm_branch(F3_BNE, 5'd11, 5'd12, 12'(loop_top)));
    exec_count += 2 * (n - 1);  // body runs n times
    emit(asm_splreg(5'd1, FIELD_X, 5'd11));
    m_x[ls] = field_t'(n);
    poison  = pick_free();
    emit(asm_li(5'd14, 20'(poison)));
    emit(asm_li(5'd13, 20'(n + 1)));
    br = prog.size();
    emit(asm_branch(F3_BEQ, 5'd11, 5'd13, 12'(br + 3)));  // n vs n+1, falls through
    emit(asm_branch(F3_BLT, 5'd12, 5'd11, 12'(br + 3)));  // n < n, falls through
    emit(asm_branch(F3_BGE, 5'd12, 5'd11, 12'(br + 4)));  // taken
    emit(asm_spli(5'd14, FIELD_KIND, 20'hBAD));
    emit(asm_jmp(25'(br + 6)));
    emit(asm_spli(5'd14, FIELD_KIND, 20'hBAD));
    exec_count -= 2;  // both poison writes skipped
    load_program();
    run_frame();
    finish_test(4, "branches and jump");

    emit(asm_li(5'd16, 20'(s0)));
    emit(asm_lisp(5'd15, 5'd16, FIELD_X));
    dst = pick_free();
    place(dst, nonzero_field(), any_field(), '0, any_field());
    emit(asm_splreg(5'd1, FIELD_Y, 5'd15));
    m_y[dst] = m_x[s0];  // x of s0 copied into y
    d0 = pick_free();
    place(d0, nonzero_field(), any_field(), any_field(), any_field());
    d1 = pick_free();
    place(d1, nonzero_field(), any_field(), any_field(), any_field());
    emit(asm_li(5'd17, 20'(d0)));
    emit(asm_li(5'd18, 20'(d1)));
    emit(asm_dist(5'd19, 5'd17, 5'd18));
    dd = pick_free();
    place(dd, nonzero_field(), any_field(), any_field(), any_field());
    emit(asm_splreg(5'd1, FIELD_X, 5'd19));
    dx = (m_x[d0] > m_x[d1]) ? int'(m_x[d0]) - int'(m_x[d1]) : int'(m_x[d1]) - int'(m_x[d0]);
    dy = (m_y[d0] > m_y[d1]) ? int'(m_y[d0]) - int'(m_y[d1]) : int'(m_y[d1]) - int'(m_y[d0]);
    m_x[dd] = field_t'(dx + dy);  // manhattan
    load_program();
    run_frame();
    finish_test(5, "LISP and DIST");

    // old program loops at 200, out of the way of the new one
    so = pick_free();
    place(so, nonzero_field(), any_field(), any_field(), any_field());
    emit(asm_jmp(25'd200));
    for (int i = 0; i < prog.size(); i++) begin
      write_word(8'(200 + i), prog[i]);
    end
    write_word(8'd0, asm_jmp(25'd200));
    @(posedge pixel_clk_in);
    prog_we <= 1'b0;
    prog.delete();
    exec_count = 0;
    repeat (40) @(posedge pixel_clk_in);
    place(so, nonzero_field(), any_field(), any_field(), any_field());
    load_program();  // word 0 lands while the loop still runs
    run_frame();
    finish_test(6, "restart");

    $display("%0d tests passed, %0d failed", pass_tests, fail_tests);
    if (fail_tests == 0 && err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG) @(posedge pixel_clk_in);
    $display("timeout: run still going after %0d cycles", WATCHDOG);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
source/sprite_pkg.sv
source/sprite_port_if.sv
source/program_rom.sv
source/core_control.sv
source/reg_file.sv
source/exec_unit.sv
source/sprite_table.sv
source/sprite_scanout.sv
source/sprite_core_top.sv
tests/sprite_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module sprite_core_tb -f sim.f -Mdir obj_dir

./obj_dir/Vsprite_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
grep -q "Test OK" sim.log
